// File: sources.f
+incdir+.
mulDivPkg.sv
mulDivIntake.sv
mulDivControl.sv
mulDivDatapath.sv
mulDivOutput.sv
mulDivTop.sv
tbMulDivChecker.sv
tbMulDiv.sv

// File: Makefile
SIM := obj_dir/VtbMulDiv

.PHONY: all run clean

all: run

$(SIM): sources.f $(wildcard *.sv *.svh)
	verilator --binary --timing --assert -Wno-fatal --top-module tbMulDiv -f sources.f

run: $(SIM)
	./$(SIM) | tee sim.log
	@if grep -qF '*** FAILED ***' sim.log; then echo "simulation failed"; exit 1; fi
	@grep -qF '*** PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log

// File: tbMulDiv.sv
`timescale 1ns/1ps
`default_nettype none
`include "mulDiv_cfg.svh"

module tbMulDiv import mulDivPkg::*; ();

    localparam logic signed [`MD_WIDTH-1:0] mostNeg = {1'b1, {(`MD_WIDTH-1){1'b0}}};
    localparam logic signed [`MD_WIDTH-1:0] mostPos = {1'b0, {(`MD_WIDTH-1){1'b1}}};
    localparam int resetCycles = 16;
    localparam int numOps      = 25 + 200 + 120 + 16 + 4; // every run the stimulus issues

    logic                        Clk;
    logic                        rstN;
    logic                        run;
    logic                        div;
    logic signed [`MD_WIDTH-1:0] opA;
    logic signed [`MD_WIDTH-1:0] opB;
    mdResult_u                   result;
    logic                        done;
    logic                        ready;
    int                          passCount;
    int                          failCount;
    int                          otherErrors;
    int                          pendingCount;
    int                          tbErrors = 0;
    int                          seed;
    logic signed [`MD_WIDTH-1:0] randA;
    logic signed [`MD_WIDTH-1:0] randB;
    logic signed [`MD_WIDTH-1:0] edgeVals [5];
    logic signed [`MD_WIDTH-1:0] divA [16];
    logic signed [`MD_WIDTH-1:0] divB [16];

    mulDivTop u_dut (.Clk, .rstN, .run, .div, .opA, .opB, .result, .done, .ready);

    tbMulDivChecker u_check (
        .Clk, .rstN, .run, .div, .opA, .opB, .result, .done, .ready,
        .passCount, .failCount, .otherErrors, .pendingCount
    );

    initial begin
        Clk = 1'b0;
        forever #4 Clk = ~Clk;                   // 8 ns period
    end

    // called 1 ns after an edge, returns 1 ns after the edge that shows done
    task automatic waitDone;
        int waited;
        waited = 0;
        while (!done && waited < 50) begin
            @(posedge Clk);
            #1;
            waited++;
        end
        if (!done) begin
            tbErrors++;
            $display("no done within 50 cycles, the DUT looks stuck");
        end
    endtask

    task automatic runOp(input logic isDiv, input logic signed [`MD_WIDTH-1:0] a,
                         input logic signed [`MD_WIDTH-1:0] b);
        run = 1'b1;
        div = isDiv;
        opA = a;
        opB = b;
        @(posedge Clk);
        #1;
        run = 1'b0;
        waitDone();
    endtask

    // a second run lands gap cycles into the first one and has to be dropped
    task automatic runWithIntrusion(input logic isDiv, input logic signed [`MD_WIDTH-1:0] a,
                                    input logic signed [`MD_WIDTH-1:0] b, input int gap,
                                    input logic intrDiv, input logic signed [`MD_WIDTH-1:0] intrA,
                                    input logic signed [`MD_WIDTH-1:0] intrB);
        run = 1'b1;
        div = isDiv;
        opA = a;
        opB = b;
        @(posedge Clk);
        #1;
        run = 1'b0;
        repeat (gap) begin
            @(posedge Clk);
            #1;
        end
        run = 1'b1;
        div = intrDiv;
        opA = intrA;
        opB = intrB;
        @(posedge Clk);
        #1;
        run = 1'b0;
        waitDone();
    endtask

    initial begin
        repeat (resetCycles + numOps * 40) @(posedge Clk);
        $display("watchdog expired after %0d cycles", resetCycles + numOps * 40);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        seed     = 32'h60af_614b;
        rstN     = 1'b0;
        run      = 1'b0;
        div      = 1'b0;
        opA      = '0;
        opB      = '0;
        edgeVals = '{0, 1, -1, mostNeg, mostPos};
        divA = '{5, -5, 0, mostNeg, mostPos, mostNeg, mostNeg, mostPos,
                 -7, 7, -7, mostNeg, 0, mostPos, 1, mostNeg};
        divB = '{0, 0, 0, 0, 0, -1, 1, -1,
                 2, -2, -2, mostNeg, 5, mostNeg, mostPos, 3};
        repeat (resetCycles) @(posedge Clk);
        #1;
        rstN = 1'b1;
        for (int i = 0; i < 5; i++) begin
            for (int j = 0; j < 5; j++) begin
                runOp(1'b0, edgeVals[i], edgeVals[j]);
            end
        end
        for (int i = 0; i < 200; i++) begin
            randA = $random(seed);
            randB = $random(seed);
            runOp(1'b0, randA, randB);
        end
        for (int i = 0; i < 120; i++) begin
            randA = $random(seed);
            randB = $random(seed);
            if (i >= 60) begin
                randB = $random(seed) % 1000;    // small divisors give wide quotients
            end
            runOp(1'b1, randA, randB);
        end
        for (int i = 0; i < 16; i++) begin
            runOp(1'b1, divA[i], divB[i]);
        end
        runWithIntrusion(1'b0, mostPos, mostNeg, 0, 1'b1, 9, 3);
        runWithIntrusion(1'b1, -1000000007, 13, 10, 1'b0, 2, 2); // divide right after a multiply
        randA = $random(seed);
        randB = $random(seed);
        runWithIntrusion(1'b0, randA, randB, 20, 1'b1, mostNeg, -1);
        runOp(1'b1, 77, 0);
        repeat (2) @(posedge Clk);
        if (pendingCount != 0) begin
            $display("%0d operations never produced done", pendingCount);
        end
        $display("tests passed %0d, failed %0d, other errors %0d", passCount, failCount,
                 otherErrors + tbErrors);
        if (failCount == 0 && otherErrors == 0 && tbErrors == 0 && pendingCount == 0 &&
            passCount == numOps + 1) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tbMulDivChecker.sv
`timescale 1ns/1ps
`default_nettype none
`include "mulDiv_cfg.svh"

module tbMulDivChecker import mulDivPkg::*; (
    input  logic                        Clk,
    input  logic                        rstN,
    input  logic                        run,
    input  logic                        div,
    input  logic signed [`MD_WIDTH-1:0] opA,
    input  logic signed [`MD_WIDTH-1:0] opB,
    input  mdResult_u                   result,
    input  logic                        done,
    input  logic                        ready,
    output int                          passCount,
    output int                          failCount,
    output int                          otherErrors,
    output int                          pendingCount
);

    localparam int latency = `MD_WIDTH + 4;      // edges from the run sample to the done edge

    mdResult_u expQ[$];                           // expected words, oldest first
    string     nameQ[$];
    int        edgeQ[$];                          // edge that sampled each accepted run
    int        edgeCount = 0;
    int        testIndex = 0;
    int        age;
    bit        resetSeen = 1'b0;

    initial begin
        passCount    = 0;
        failCount    = 0;
        otherErrors  = 0;
        pendingCount = 0;
    end

    // full signed product, or a quotient truncated toward zero with a dividend-signed remainder
    function automatic mdResult_u expectedResult(input logic isDiv,
                                                 input logic signed [`MD_WIDTH-1:0] a,
                                                 input logic signed [`MD_WIDTH-1:0] b);
        longint    wideA;
        longint    wideB;
        longint    quot;
        longint    rem;
        mdResult_u res;
        wideA = a;                                // sign extends to 64 bits
        wideB = b;
        if (!isDiv) begin
            res = wideA * wideB;
        end else if (b == 0) begin
            res.qr.quot = '1;                     // divide by zero gives all ones and the dividend
            res.qr.rem  = a;
        end else begin
            quot = wideA / wideB;                 // most negative over -1 wraps back to itself
            rem  = wideA % wideB;
            res.qr.quot = quot[`MD_WIDTH-1:0];
            res.qr.rem  = rem[`MD_WIDTH-1:0];
        end
        return res;
    endfunction

    task automatic finishTest(input bit timedOut);
        mdResult_u expected;
        string     name;
        int        took;
        expected = expQ.pop_front();
        name     = nameQ.pop_front();
        took     = edgeCount - edgeQ.pop_front();
        if (timedOut) begin
            failCount++;
            $display("FAIL %s: no done within %0d cycles of run", name, latency);
        end else if (took != latency) begin
            failCount++;
            $display("FAIL %s: done came %0d cycles after run, not %0d", name, took, latency);
        end else if (result !== expected) begin
            failCount++;
            $display("ERROR %s expected %h actual %h", name, expected, result);
        end else begin
            passCount++;
            $display("PASS %s -> %h", name, result);
        end
    endtask

    always @(posedge Clk) begin
        edgeCount <= edgeCount + 1;
    end

    // sampled mid-cycle, where DUT outputs and driven inputs have both settled
    always @(negedge Clk) begin
        if (rstN) begin
            if (!resetSeen) begin
                resetSeen = 1'b1;                 // first look at the unit after reset
                if (ready && !done) begin
                    passCount++;
                    $display("PASS reset state");
                end else begin
                    failCount++;
                    $display("ERROR reset state expected ready=1 done=0 actual ready=%b done=%b",
                             ready, done);
                end
            end
            if (done) begin
                if (expQ.size() == 0) begin
                    otherErrors++;
                    $display("done pulsed at cycle %0d with no operation in flight", edgeCount);
                end else begin
                    finishTest(1'b0);
                end
            end
            if (expQ.size() != 0) begin
                age = edgeCount - edgeQ[0];
                if (age > latency) begin
                    finishTest(1'b1);             // give up on it so later tests still line up
                end else if (age >= 1 && age < latency && ready) begin
                    otherErrors++;
                    $display("ready was high while %s was still running", nameQ[0]);
                end
            end else if (!ready) begin
                otherErrors++;
                $display("ready was low at cycle %0d with nothing in flight", edgeCount);
            end
            // a run seen while something is in flight must be dropped by the DUT
            if (run && expQ.size() == 0) begin
                expQ.push_back(expectedResult(div, opA, opB));
                nameQ.push_back($sformatf("t%0d %s %0d, %0d", testIndex,
                                          div ? "div" : "mul", opA, opB));
                edgeQ.push_back(edgeCount + 1);   // the coming edge samples run
                testIndex++;
            end
            pendingCount = expQ.size();
        end
    end

endmodule

`default_nettype wire

// File: mulDivTop.sv
`timescale 1ns/1ps
`default_nettype none
`include "mulDiv_cfg.svh"

module mulDivTop import mulDivPkg::*; (
    input  logic                        Clk,
    input  logic                        rstN,
    input  logic                        run,
    input  logic                        div,
    input  logic signed [`MD_WIDTH-1:0] opA,
    input  logic signed [`MD_WIDTH-1:0] opB,
    output mdResult_u                   result,
    output logic                        done,
    output logic                        ready
);

    mdRequest_t           req;
    mdSign_t              sign;
    logic                 start;
    logic                 loadRegs;
    logic                 shiftEn;
    logic                 finish;
    logic [`MD_WIDTH-1:0] accHi;
    logic [`MD_WIDTH-1:0] accLo;

    mulDivIntake intake (
        .Clk, .rstN, .run, .div, .opA, .opB, .ready,
        .req, .sign, .start
    );

    mulDivControl control (
        .Clk, .rstN, .start,
        .loadRegs, .shiftEn,
        .lastStep(),                               // only the control FSM itself steers on it
        .finish, .ready
    );

    mulDivDatapath datapath (
        .Clk, .rstN, .req, .loadRegs, .shiftEn,
        .accHi, .accLo
    );

    mulDivOutput outSide (
        .Clk, .rstN, .finish,
        .div(req.div),                             // mode of the operation in flight
        .sign, .accHi, .accLo,
        .result, .done
    );

endmodule

`default_nettype wire

// File: mulDivOutput.sv
`timescale 1ns/1ps
`default_nettype none
`include "mulDiv_cfg.svh"

module mulDivOutput import mulDivPkg::*; (
    input  logic                 Clk,
    input  logic                 rstN,
    input  logic                 finish,
    input  logic                 div,
    input  mdSign_t              sign,
    input  logic [`MD_WIDTH-1:0] accHi,
    input  logic [`MD_WIDTH-1:0] accLo,
    output mdResult_u            result,
    output logic                 done
);

    logic [2*`MD_WIDTH-1:0] product;
    mdResult_u              word;

    assign product = {accHi, accLo};

    always_comb begin
        if (div) begin
            // quotient and remainder carry their own signs
            word.qr.quot = sign.divByZero ? '1 : (sign.negResult ? -accLo : accLo);
            word.qr.rem  = sign.negRem ? -accHi : accHi; // x/0 leaves |dividend| in A
        end else begin
            word.prod = sign.negResult ? -product : product; // full-width negate of the product
        end
    end

    // result holds steady between done pulses
    always_ff @(posedge Clk) begin
        if (finish) begin
            result <= word;
        end
    end

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            done <= 1'b0;
        end else begin
            done <= finish;                        // lines up with the result register
        end
    end

endmodule

`default_nettype wire

// File: mulDivDatapath.sv
`timescale 1ns/1ps
`default_nettype none
`include "mulDiv_cfg.svh"

module mulDivDatapath import mulDivPkg::*; (
    input  logic                 Clk,
    input  logic                 rstN,
    input  mdRequest_t           req,
    input  logic                 loadRegs,
    input  logic                 shiftEn,
    output logic [`MD_WIDTH-1:0] accHi,           // raw A, product high half or remainder
    output logic [`MD_WIDTH-1:0] accLo            // raw B, product low half or quotient
);

    localparam int W = `MD_WIDTH;

    logic [W:0]   regA;                           // accumulator, one bit wider than the data
    logic [W-1:0] regB;                           // multiplier or dividend, shifted with A
    logic [W:0]   addX;
    logic [W:0]   addY;
    logic [W:0]   sum;
    logic         sub;
    logic         qBit;
    logic [W:0]   mulPick;

    // a divide step works on A:B already moved left by one bit
    assign addX = req.div ? {regA[W-1:0], regB[W-1]} : regA;
    assign addY = {1'b0, req.div ? req.magB : req.magA}; // divisor or multiplicand
    assign sub  = req.div;                        // the one adder subtracts in divide mode

    // two's complement subtract is invert plus carry in
    assign sum = addX + (addY ^ {(W + 1){sub}}) + {{W{1'b0}}, sub};

    // in a divide the remainder stays below the divisor, so W+1 bits hold the sign
    assign qBit = ~sum[W];

    // multiply adds only when the current multiplier bit is set
    assign mulPick = regB[0] ? sum : regA;

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            regA <= '0;
        end else if (loadRegs) begin
            regA <= '0;
        end else if (shiftEn) begin
            if (req.div) begin
                regA <= qBit ? sum : addX;         // keep difference or restore shifted value
            end else begin
                regA <= {1'b0, mulPick[W:1]};      // carry drops into the top data bit
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (loadRegs) begin
            regB <= req.div ? req.magA : req.magB; // dividend or multiplier
        end else if (shiftEn) begin
            if (req.div) begin
                regB <= {regB[W-2:0], qBit};       // quotient bits enter from the bottom
            end else begin
                regB <= {mulPick[0], regB[W-1:1]}; // low bit of A moves into B
            end
        end
    end

    assign accHi = regA[W-1:0];
    assign accLo = regB;

    // restoring division keeps the partial remainder under the divisor after every step
    assert property (@(posedge Clk) disable iff (!rstN)
        shiftEn && req.div && (req.magB != '0) |=> regA < {1'b0, req.magB})
        else $error("datapath: partial remainder reached the divisor");

endmodule

`default_nettype wire

// File: mulDivControl.sv
`timescale 1ns/1ps
`default_nettype none
`include "mulDiv_cfg.svh"

module mulDivControl (
    input  logic Clk,
    input  logic rstN,
    input  logic start,       // pulse from the intake
    output logic loadRegs,    // clear A and load B
    output logic shiftEn,     // one iteration per cycle
    output logic lastStep,    // final iteration of the run
    output logic finish,      // result is complete in the datapath
    output logic ready
);

    typedef enum logic [1:0] {
        sIdle,
        sLoad,
        sIter,
        sFin
    } ctlState_t;

    ctlState_t            state;
    logic [`MD_CNT_W-1:0] count;                  // iterations left after the current one

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            state <= sIdle;
            count <= '0;
        end else begin
            case (state)
                sIdle: begin
                    if (start) begin
                        state <= sLoad;
                    end
                end
                sLoad: begin
                    state <= sIter;
                    count <= `MD_CNT_W'(`MD_WIDTH - 1); // MD_WIDTH steps counting down to zero
                end
                sIter: begin
                    count <= count - 1'b1;
                    if (lastStep) begin
                        state <= sFin;
                    end
                end
                sFin: begin
                    state <= sIdle;               // done goes out on the same edge
                end
                default: begin
                    state <= sIdle;
                end
            endcase
        end
    end

    assign loadRegs = (state == sLoad);
    assign shiftEn  = (state == sIter);
    assign lastStep = shiftEn && (count == '0);
    assign finish   = (state == sFin);
    assign ready    = (state == sIdle) && !start; // drops as soon as start shows up

    assert property (@(posedge Clk) disable iff (!rstN) !(loadRegs && shiftEn))
        else $error("control: load and shift asserted together");

    // finish is a single-cycle strobe, the output side latches on it once
    assert property (@(posedge Clk) disable iff (!rstN) finish |=> !finish)
        else $error("control: finish held for more than one cycle");

endmodule

`default_nettype wire

// File: mulDivIntake.sv
`timescale 1ns/1ps
`default_nettype none
`include "mulDiv_cfg.svh"

module mulDivIntake import mulDivPkg::*; (
    input  logic                        Clk,
    input  logic                        rstN,
    input  logic                        run,      // one-cycle strobe from the user
    input  logic                        div,      // mode level, sampled with run
    input  logic signed [`MD_WIDTH-1:0] opA,
    input  logic signed [`MD_WIDTH-1:0] opB,
    input  logic                        ready,    // control is idle
    output mdRequest_t                  req,
    output mdSign_t                     sign,
    output logic                        start
);

    logic                 taken;                  // high the cycle after a run was accepted
    logic                 accept;
    logic                 negA;
    logic                 negB;
    logic                 zeroB;
    logic [`MD_WIDTH-1:0] magA;
    logic [`MD_WIDTH-1:0] magB;

    assign negA   = opA[`MD_WIDTH-1];             // sign bits of the raw operands
    assign negB   = opB[`MD_WIDTH-1];
    assign zeroB  = (opB == '0);
    assign magA   = negA ? -opA : opA;            // most negative value maps to 2**(W-1)
    assign magB   = negB ? -opB : opB;
    assign accept = run && ready && !taken;       // taken closes the gap before ready drops

    // the captured operation stays put until the next accepted run
    always_ff @(posedge Clk) begin
        if (accept) begin
            req.div  <= div;
            req.magA <= magA;
            req.magB <= magB;
            sign.negResult <= (negA ^ negB) && !(div && zeroB); // x/0 keeps quotient all ones
            sign.negRem    <= div && negA;                      // remainder follows the dividend
            sign.divByZero <= div && zeroB;
        end
    end

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            taken <= 1'b0;
            start <= 1'b0;
        end else begin
            taken <= accept;
            start <= taken;                       // start trails the capture by one cycle
        end
    end

    // a start pulse must come from a run that was taken while the unit was idle
    assert property (@(posedge Clk) disable iff (!rstN) $rose(start) |-> $past(ready, 1))
        else $error("intake: start rose while the unit was busy");

endmodule

`default_nettype wire

// File: mulDivPkg.sv
`default_nettype none
`include "mulDiv_cfg.svh"

package mulDivPkg;

    typedef struct packed {
        logic                 div;       // 1 selects restoring divide, 0 selects multiply
        logic [`MD_WIDTH-1:0] magA;      // magnitude of opA, multiplicand or dividend
        logic [`MD_WIDTH-1:0] magB;      // magnitude of opB, multiplier or divisor
    } mdRequest_t;

    typedef struct packed {
        logic negResult;                 // negate the product or the quotient at the end
        logic negRem;                    // negate the remainder, follows the dividend
        logic divByZero;                 // divisor was zero so the quotient is forced
    } mdSign_t;

    typedef struct packed {
        logic [`MD_WIDTH-1:0] hi;        // upper half of the signed product
        logic [`MD_WIDTH-1:0] lo;        // lower half of the signed product
    } mdProduct_t;

    typedef struct packed {
        logic [`MD_WIDTH-1:0] rem;       // remainder sits in the upper half
        logic [`MD_WIDTH-1:0] quot;      // quotient sits in the lower half
    } mdQuotRem_t;

    // the same 64-bit word is read as a product or as a quotient/remainder pair
    typedef union packed {
        mdProduct_t prod;
        mdQuotRem_t qr;
    } mdResult_u;

endpackage

`default_nettype wire

// File: mulDiv_cfg.svh
`ifndef MULDIV_CFG_SVH
`define MULDIV_CFG_SVH

// operand width, every data path is sized from it
// the accumulator register A carries one extra bit for carry and sign
`define MD_WIDTH 32

// down counter width, wide enough to hold MD_WIDTH-1
`define MD_CNT_W 6

`endif
